// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_mips_id_ex
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
+incdir+rtl
rtl/mips_pkg.sv
rtl/reg_file.sv
rtl/control_decoder.sv
rtl/id_ex.sv
rtl/ex_stage.sv
rtl/mips_id_ex_top.sv
tests/id_ex_properties.sv
tests/tb_mips_id_ex.sv

// ==== rtl/control_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module control_decoder (
    input  wire mips_pkg::ins_word_t ins_word,
    output logic                     ext_op,
    output logic                     alu_src,
    output logic [1:0]               reg_dst,
    output logic [1:0]               branch,
    output logic [1:0]               jump,
    output logic                     reg_wr,
    output logic [3:0]               alu_ctr,
    output logic [15:0]              imm16
);

    logic [5:0] op;
    logic [5:0] funct;

    assign op    = ins_word.i.op;
    assign funct = ins_word.r.funct;
    assign imm16 = ins_word.i.imm16;

    always_comb begin
        // Defaults describe an instruction with no effect.
        ext_op  = 1'b0;
        alu_src = 1'b0;
        reg_dst = `MIPS_DST_RT;
        branch  = `MIPS_BR_NONE;
        jump    = `MIPS_JMP_NONE;
        reg_wr  = 1'b0;
        alu_ctr = `MIPS_ALU_ADD;
        case (op)
            `MIPS_OP_RTYPE: begin
                reg_dst = `MIPS_DST_RD;
                reg_wr  = 1'b1;
                case (funct)
                    `MIPS_FN_ADDU: alu_ctr = `MIPS_ALU_ADD;
                    `MIPS_FN_SUBU: alu_ctr = `MIPS_ALU_SUB;
                    `MIPS_FN_AND:  alu_ctr = `MIPS_ALU_AND;
                    `MIPS_FN_OR:   alu_ctr = `MIPS_ALU_OR;
                    `MIPS_FN_XOR:  alu_ctr = `MIPS_ALU_XOR;
                    `MIPS_FN_SLT:  alu_ctr = `MIPS_ALU_SLT;
                    `MIPS_FN_SLL:  alu_ctr = `MIPS_ALU_SLL;
                    default:       reg_wr  = 1'b0;
                endcase
            end
            `MIPS_OP_ADDIU: begin
                ext_op  = 1'b1;
                alu_src = 1'b1;
                reg_wr  = 1'b1;
            end
            `MIPS_OP_ANDI: begin
                alu_src = 1'b1;
                reg_wr  = 1'b1;
                alu_ctr = `MIPS_ALU_AND;
            end
            `MIPS_OP_ORI: begin
                alu_src = 1'b1;
                reg_wr  = 1'b1;
                alu_ctr = `MIPS_ALU_OR;
            end
            `MIPS_OP_XORI: begin
                alu_src = 1'b1;
                reg_wr  = 1'b1;
                alu_ctr = `MIPS_ALU_XOR;
            end
            `MIPS_OP_LUI: begin
                alu_src = 1'b1;
                reg_wr  = 1'b1;
                alu_ctr = `MIPS_ALU_LUI;
            end
            `MIPS_OP_BEQ: begin
                branch  = `MIPS_BR_EQ;
                alu_ctr = `MIPS_ALU_SUB;
            end
            `MIPS_OP_BNE: begin
                branch  = `MIPS_BR_NE;
                alu_ctr = `MIPS_ALU_SUB;
            end
            `MIPS_OP_J:   jump = `MIPS_JMP_J;
            `MIPS_OP_JAL: begin
                jump    = `MIPS_JMP_JAL;
                reg_dst = `MIPS_DST_R31;
                reg_wr  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module ex_stage (
    input  wire logic                  ex_valid,
    input  wire logic [`MIPS_PCW-1:0]  ex_pc,
    input  wire mips_pkg::ins_word_t   ex_ins,
    input  wire logic [`MIPS_XLEN-1:0] ex_busa,
    input  wire logic [`MIPS_XLEN-1:0] ex_busb,
    input  wire logic [15:0]           ex_imm16,
    input  wire logic [`MIPS_REGW-1:0] ex_rt,
    input  wire logic [`MIPS_REGW-1:0] ex_rd,
    input  wire logic                  ex_ext_op,
    input  wire logic                  ex_alu_src,
    input  wire logic [1:0]            ex_reg_dst,
    input  wire logic [1:0]            ex_branch,
    input  wire logic [1:0]            ex_jump,
    input  wire logic                  ex_reg_wr,
    input  wire logic [3:0]            ex_alu_ctr,
    output logic                       wb_en,
    output logic      [`MIPS_REGW-1:0] wb_reg,
    output logic      [`MIPS_XLEN-1:0] wb_data,
    output logic                       redirect,
    output logic      [`MIPS_PCW-1:0]  redirect_pc
);

    logic [`MIPS_XLEN-1:0] ext_imm;
    logic [`MIPS_XLEN-1:0] opb;
    logic [`MIPS_XLEN-1:0] alu_out;
    logic [`MIPS_PCW-1:0]  pc_plus1;
    logic [`MIPS_PCW-1:0]  pc_plus2;
    logic [`MIPS_PCW-1:0]  br_target;
    logic [`MIPS_PCW-1:0]  jmp_target;
    logic                  br_taken;

    assign ext_imm = ex_ext_op ? {{16{ex_imm16[15]}}, ex_imm16} : {16'h0000, ex_imm16};
    assign opb     = ex_alu_src ? ext_imm : ex_busb;

    always_comb begin
        case (ex_alu_ctr)
            `MIPS_ALU_SUB: alu_out = ex_busa - opb;
            `MIPS_ALU_AND: alu_out = ex_busa & opb;
            `MIPS_ALU_OR:  alu_out = ex_busa | opb;
            `MIPS_ALU_XOR: alu_out = ex_busa ^ opb;
            `MIPS_ALU_SLT: alu_out = {31'd0, $signed(ex_busa) < $signed(opb)};
            `MIPS_ALU_SLL: alu_out = opb << ex_ins.r.shamt;
            `MIPS_ALU_LUI: alu_out = {opb[15:0], 16'h0000};
            default:       alu_out = ex_busa + opb;
        endcase
    end

    always_comb begin
        case (ex_reg_dst)
            `MIPS_DST_RD:  wb_reg = ex_rd;
            `MIPS_DST_R31: wb_reg = 5'd31;
            default:       wb_reg = ex_rt;
        endcase
    end

    assign pc_plus1 = ex_pc + 1'b1;
    assign pc_plus2 = ex_pc + 2'd2;

    // Link address skips the delay slot, stored as a byte address.
    assign wb_data = (ex_jump == `MIPS_JMP_JAL) ? {pc_plus2, 2'b00} : alu_out;
    assign wb_en   = ex_valid && ex_reg_wr && (wb_reg != '0);

    assign br_taken = ((ex_branch == `MIPS_BR_EQ) && (ex_busa == ex_busb)) ||
                      ((ex_branch == `MIPS_BR_NE) && (ex_busa != ex_busb));

    assign br_target  = pc_plus1 + {{(`MIPS_PCW-16){ex_imm16[15]}}, ex_imm16};
    assign jmp_target = {pc_plus1[`MIPS_PCW-1 -: 4], ex_ins.j.target26};

    assign redirect    = ex_valid && (br_taken || (ex_jump != `MIPS_JMP_NONE));
    assign redirect_pc = (ex_jump != `MIPS_JMP_NONE) ? jmp_target : br_target;

endmodule

`default_nettype wire

// ==== rtl/id_ex.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module id_ex (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     id_valid,
    input  wire logic [`MIPS_PCW-1:0]     id_pc,
    input  wire mips_pkg::ins_word_t      id_ins,
    input  wire logic [`MIPS_XLEN-1:0]    id_busa,
    input  wire logic [`MIPS_XLEN-1:0]    id_busb,
    input  wire logic [15:0]              id_imm16,
    input  wire logic [`MIPS_REGW-1:0]    id_rt,
    input  wire logic [`MIPS_REGW-1:0]    id_rd,
    input  wire logic                     id_ext_op,
    input  wire logic                     id_alu_src,
    input  wire logic [1:0]               id_reg_dst,
    input  wire logic [1:0]               id_branch,
    input  wire logic [1:0]               id_jump,
    input  wire logic                     id_reg_wr,
    input  wire logic [3:0]               id_alu_ctr,
    output logic                          ex_valid,
    output logic      [`MIPS_PCW-1:0]     ex_pc,
    output mips_pkg::ins_word_t           ex_ins,
    output logic      [`MIPS_XLEN-1:0]    ex_busa,
    output logic      [`MIPS_XLEN-1:0]    ex_busb,
    output logic      [15:0]              ex_imm16,
    output logic      [`MIPS_REGW-1:0]    ex_rt,
    output logic      [`MIPS_REGW-1:0]    ex_rd,
    output logic                          ex_ext_op,
    output logic                          ex_alu_src,
    output logic      [1:0]               ex_reg_dst,
    output logic      [1:0]               ex_branch,
    output logic      [1:0]               ex_jump,
    output logic                          ex_reg_wr,
    output logic      [3:0]               ex_alu_ctr
);

    // Control stage. An empty decode slot becomes a bubble.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid   <= 1'b0;
            ex_ext_op  <= 1'b0;
            ex_alu_src <= 1'b0;
            ex_reg_dst <= `MIPS_DST_RT;
            ex_branch  <= `MIPS_BR_NONE;
            ex_jump    <= `MIPS_JMP_NONE;
            ex_reg_wr  <= 1'b0;
            ex_alu_ctr <= `MIPS_ALU_ADD;
        end else if (id_valid) begin
            ex_valid   <= 1'b1;
            ex_ext_op  <= id_ext_op;
            ex_alu_src <= id_alu_src;
            ex_reg_dst <= id_reg_dst;
            ex_branch  <= id_branch;
            ex_jump    <= id_jump;
            ex_reg_wr  <= id_reg_wr;
            ex_alu_ctr <= id_alu_ctr;
        end else begin
            ex_valid   <= 1'b0;
            ex_ext_op  <= 1'b0;
            ex_alu_src <= 1'b0;
            ex_reg_dst <= `MIPS_DST_RT;
            ex_branch  <= `MIPS_BR_NONE;
            ex_jump    <= `MIPS_JMP_NONE;
            ex_reg_wr  <= 1'b0;
            ex_alu_ctr <= `MIPS_ALU_ADD;
        end
    end

    // Operands and instruction fields.
    always_ff @(posedge clk) begin
        ex_pc    <= id_pc;
        ex_ins   <= id_ins;
        ex_busa  <= id_busa;
        ex_busb  <= id_busb;
        ex_imm16 <= id_imm16;
        ex_rt    <= id_rt;
        ex_rd    <= id_rd;
    end

endmodule

`default_nettype wire

// ==== rtl/mips_id_ex_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module mips_id_ex_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  ins_valid,
    input  wire logic [`MIPS_PCW-1:0]  ins_pc,
    input  wire mips_pkg::ins_word_t   ins_word,
    output logic                       wb_valid,
    output logic      [`MIPS_REGW-1:0] wb_reg,
    output logic      [`MIPS_XLEN-1:0] wb_data,
    output logic                       redirect,
    output logic      [`MIPS_PCW-1:0]  redirect_pc
);

    logic                  id_ext_op;
    logic                  id_alu_src;
    logic [1:0]            id_reg_dst;
    logic [1:0]            id_branch;
    logic [1:0]            id_jump;
    logic                  id_reg_wr;
    logic [3:0]            id_alu_ctr;
    logic [15:0]           id_imm16;
    logic [`MIPS_XLEN-1:0] id_busa;
    logic [`MIPS_XLEN-1:0] id_busb;

    logic                  ex_valid;
    logic [`MIPS_PCW-1:0]  ex_pc;
    mips_pkg::ins_word_t   ex_ins;
    logic [`MIPS_XLEN-1:0] ex_busa;
    logic [`MIPS_XLEN-1:0] ex_busb;
    logic [15:0]           ex_imm16;
    logic [`MIPS_REGW-1:0] ex_rt;
    logic [`MIPS_REGW-1:0] ex_rd;
    logic                  ex_ext_op;
    logic                  ex_alu_src;
    logic [1:0]            ex_reg_dst;
    logic [1:0]            ex_branch;
    logic [1:0]            ex_jump;
    logic                  ex_reg_wr;
    logic [3:0]            ex_alu_ctr;

    control_decoder control_decoder_inst (
        .ins_word (ins_word),
        .ext_op   (id_ext_op),
        .alu_src  (id_alu_src),
        .reg_dst  (id_reg_dst),
        .branch   (id_branch),
        .jump     (id_jump),
        .reg_wr   (id_reg_wr),
        .alu_ctr  (id_alu_ctr),
        .imm16    (id_imm16)
    );

    // Write port is fed back from execute.
    reg_file reg_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .ra_reg  (ins_word.r.rs),
        .rb_reg  (ins_word.r.rt),
        .wb_en   (wb_valid),
        .wb_reg  (wb_reg),
        .wb_data (wb_data),
        .ra_data (id_busa),
        .rb_data (id_busb)
    );

    id_ex id_ex_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_valid   (ins_valid),
        .id_pc      (ins_pc),
        .id_ins     (ins_word),
        .id_busa    (id_busa),
        .id_busb    (id_busb),
        .id_imm16   (id_imm16),
        .id_rt      (ins_word.r.rt),
        .id_rd      (ins_word.r.rd),
        .id_ext_op  (id_ext_op),
        .id_alu_src (id_alu_src),
        .id_reg_dst (id_reg_dst),
        .id_branch  (id_branch),
        .id_jump    (id_jump),
        .id_reg_wr  (id_reg_wr),
        .id_alu_ctr (id_alu_ctr),
        .ex_valid   (ex_valid),
        .ex_pc      (ex_pc),
        .ex_ins     (ex_ins),
        .ex_busa    (ex_busa),
        .ex_busb    (ex_busb),
        .ex_imm16   (ex_imm16),
        .ex_rt      (ex_rt),
        .ex_rd      (ex_rd),
        .ex_ext_op  (ex_ext_op),
        .ex_alu_src (ex_alu_src),
        .ex_reg_dst (ex_reg_dst),
        .ex_branch  (ex_branch),
        .ex_jump    (ex_jump),
        .ex_reg_wr  (ex_reg_wr),
        .ex_alu_ctr (ex_alu_ctr)
    );

    ex_stage ex_stage_inst (
        .ex_valid    (ex_valid),
        .ex_pc       (ex_pc),
        .ex_ins      (ex_ins),
        .ex_busa     (ex_busa),
        .ex_busb     (ex_busb),
        .ex_imm16    (ex_imm16),
        .ex_rt       (ex_rt),
        .ex_rd       (ex_rd),
        .ex_ext_op   (ex_ext_op),
        .ex_alu_src  (ex_alu_src),
        .ex_reg_dst  (ex_reg_dst),
        .ex_branch   (ex_branch),
        .ex_jump     (ex_jump),
        .ex_reg_wr   (ex_reg_wr),
        .ex_alu_ctr  (ex_alu_ctr),
        .wb_en       (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== rtl/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define MIPS_XLEN 32
`define MIPS_PCW 30
`define MIPS_REGW 5

// Primary opcodes.
`define MIPS_OP_RTYPE 6'h00
`define MIPS_OP_J 6'h02
`define MIPS_OP_JAL 6'h03
`define MIPS_OP_BEQ 6'h04
`define MIPS_OP_BNE 6'h05
`define MIPS_OP_ADDIU 6'h09
`define MIPS_OP_ANDI 6'h0c
`define MIPS_OP_ORI 6'h0d
`define MIPS_OP_XORI 6'h0e
`define MIPS_OP_LUI 6'h0f

// Function codes of the R-type group.
`define MIPS_FN_SLL 6'h00
`define MIPS_FN_ADDU 6'h21
`define MIPS_FN_SUBU 6'h23
`define MIPS_FN_AND 6'h24
`define MIPS_FN_OR 6'h25
`define MIPS_FN_XOR 6'h26
`define MIPS_FN_SLT 6'h2a

`define MIPS_ALU_ADD 4'd0
`define MIPS_ALU_SUB 4'd1
`define MIPS_ALU_AND 4'd2
`define MIPS_ALU_OR 4'd3
`define MIPS_ALU_XOR 4'd4
`define MIPS_ALU_SLT 4'd5
`define MIPS_ALU_SLL 4'd6
`define MIPS_ALU_LUI 4'd7

`define MIPS_BR_NONE 2'd0
`define MIPS_BR_EQ 2'd1
`define MIPS_BR_NE 2'd2

`define MIPS_DST_RT 2'd0
`define MIPS_DST_RD 2'd1
`define MIPS_DST_R31 2'd2

`define MIPS_JMP_NONE 2'd0
`define MIPS_JMP_J 2'd1
`define MIPS_JMP_JAL 2'd2

`endif

// ==== rtl/mips_pkg.sv ====
`default_nettype none

`include "mips_macros.svh"

package mips_pkg;

    typedef struct packed {
        logic [5:0]            op;
        logic [`MIPS_REGW-1:0] rs;
        logic [`MIPS_REGW-1:0] rt;
        logic [`MIPS_REGW-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } ins_r_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [`MIPS_REGW-1:0] rs;
        logic [`MIPS_REGW-1:0] rt;
        logic [15:0]           imm16;
    } ins_i_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target26;
    } ins_j_t;

    // One instruction word, seen through the three encoding formats.
    typedef union packed {
        ins_r_t r;
        ins_i_t i;
        ins_j_t j;
    } ins_word_t;

endpackage

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module reg_file (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [`MIPS_REGW-1:0] ra_reg,
    input  wire logic [`MIPS_REGW-1:0] rb_reg,
    input  wire logic                  wb_en,
    input  wire logic [`MIPS_REGW-1:0] wb_reg,
    input  wire logic [`MIPS_XLEN-1:0] wb_data,
    output logic      [`MIPS_XLEN-1:0] ra_data,
    output logic      [`MIPS_XLEN-1:0] rb_data
);

    // Register 0 has no storage.
    logic [`MIPS_XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_en && (wb_reg != '0)) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // Write-through so decode sees the value that execute retires this cycle.
    assign ra_data = (ra_reg == '0)                   ? '0      :
                     (wb_en && (wb_reg == ra_reg))    ? wb_data :
                                                        regs[ra_reg];

    assign rb_data = (rb_reg == '0)                   ? '0      :
                     (wb_en && (wb_reg == rb_reg))    ? wb_data :
                                                        regs[rb_reg];

endmodule

`default_nettype wire

// ==== tests/id_ex_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module id_ex_properties (
    input wire logic                  clk,
    input wire logic                  rst_n,
    input wire logic                  id_valid,
    input wire logic [`MIPS_PCW-1:0]  id_pc,
    input wire logic [`MIPS_XLEN-1:0] id_busa,
    input wire logic [1:0]            id_branch,
    input wire logic [1:0]            id_jump,
    input wire logic                  id_reg_wr,
    input wire logic                  ex_valid,
    input wire logic [`MIPS_PCW-1:0]  ex_pc,
    input wire logic [`MIPS_XLEN-1:0] ex_busa,
    input wire logic [1:0]            ex_branch,
    input wire logic [1:0]            ex_jump,
    input wire logic                  ex_reg_wr
);

    int unsigned fail_count = 0;

    reset_clears_valid: assert property (@(posedge clk) !rst_n |-> !ex_valid)
        else begin
            fail_count++;
            $error("ex_valid is set while reset is active");
        end

    // An empty slot must not carry any side effect into execute.
    bubble_has_no_control: assert property (@(posedge clk) disable iff (!rst_n)
        !id_valid |=> (!ex_valid && !ex_reg_wr && ex_branch == 2'd0 && ex_jump == 2'd0))
        else begin
            fail_count++;
            $error("a bubble reached execute with control set");
        end

    valid_fields_captured: assert property (@(posedge clk) disable iff (!rst_n)
        id_valid |=> (ex_valid && ex_pc == $past(id_pc) && ex_busa == $past(id_busa) &&
                      ex_reg_wr == $past(id_reg_wr) && ex_branch == $past(id_branch) &&
                      ex_jump == $past(id_jump)))
        else begin
            fail_count++;
            $error("ID/EX fields differ from the decode fields of the previous cycle");
        end

endmodule

bind id_ex id_ex_properties id_ex_properties_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .id_valid  (id_valid),
    .id_pc     (id_pc),
    .id_busa   (id_busa),
    .id_branch (id_branch),
    .id_jump   (id_jump),
    .id_reg_wr (id_reg_wr),
    .ex_valid  (ex_valid),
    .ex_pc     (ex_pc),
    .ex_busa   (ex_busa),
    .ex_branch (ex_branch),
    .ex_jump   (ex_jump),
    .ex_reg_wr (ex_reg_wr)
);

`default_nettype wire

// ==== tests/tb_mips_id_ex.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module tb_mips_id_ex;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 5;
    // Reset, bubbles, R-type rounds, immediate rounds, chain, branches.
    localparam int TOTAL_CYCLES = RESET_CYCLES + 6 + 4 * 11 + 4 * 7 + 13 + 16;

    logic                  clk;
    logic                  rst_n;
    logic                  ins_valid;
    logic [`MIPS_PCW-1:0]  ins_pc;
    mips_pkg::ins_word_t   ins_word;
    logic                  wb_valid;
    logic [`MIPS_REGW-1:0] wb_reg;
    logic [`MIPS_XLEN-1:0] wb_data;
    logic                  redirect;
    logic [`MIPS_PCW-1:0]  redirect_pc;

    logic [`MIPS_XLEN-1:0] model_regs [32];
    logic [`MIPS_PCW-1:0]  cur_pc;
    int                    checks;
    int                    errors;
    int                    prop_errors;

    mips_id_ex_top mips_id_ex_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .ins_valid   (ins_valid),
        .ins_pc      (ins_pc),
        .ins_word    (ins_word),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic mips_pkg::ins_word_t rtype_word(input logic [5:0] funct,
            input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
            input logic [4:0] shamt);
        mips_pkg::ins_word_t w;
        w.r = '{`MIPS_OP_RTYPE, rs, rt, rd, shamt, funct};
        return w;
    endfunction

    function automatic mips_pkg::ins_word_t imm_word(input logic [5:0] op,
            input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
        mips_pkg::ins_word_t w;
        w.i = '{op, rs, rt, imm};
        return w;
    endfunction

    function automatic mips_pkg::ins_word_t jump_word(input logic [5:0] op,
            input logic [25:0] target);
        mips_pkg::ins_word_t w;
        w.j = '{op, target};
        return w;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
            input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %t %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Reference model of one instruction against the mirrored registers.
    task automatic predict(input mips_pkg::ins_word_t w, input logic [29:0] pc,
            output logic wv, output logic [4:0] dst, output logic [31:0] res,
            output logic taken, output logic [29:0] tgt);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [29:0] next_pc;
        logic        wr;
        a       = model_regs[w.r.rs];
        b       = model_regs[w.r.rt];
        simm    = {{16{w.i.imm16[15]}}, w.i.imm16};
        zimm    = {16'h0000, w.i.imm16};
        next_pc = pc + 30'd1;
        wr      = 1'b1;
        dst     = w.i.rt;
        res     = '0;
        taken   = 1'b0;
        tgt     = '0;
        case (w.i.op)
            `MIPS_OP_RTYPE: begin
                dst = w.r.rd;
                case (w.r.funct)
                    `MIPS_FN_ADDU: res = a + b;
                    `MIPS_FN_SUBU: res = a - b;
                    `MIPS_FN_AND:  res = a & b;
                    `MIPS_FN_OR:   res = a | b;
                    `MIPS_FN_XOR:  res = a ^ b;
                    `MIPS_FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `MIPS_FN_SLL:  res = b << w.r.shamt;
                    default:       wr = 1'b0;
                endcase
            end
            `MIPS_OP_ADDIU: res = a + simm;
            `MIPS_OP_ANDI:  res = a & zimm;
            `MIPS_OP_ORI:   res = a | zimm;
            `MIPS_OP_XORI:  res = a ^ zimm;
            `MIPS_OP_LUI:   res = {w.i.imm16, 16'h0000};
            `MIPS_OP_BEQ, `MIPS_OP_BNE: begin
                wr    = 1'b0;
                taken = (w.i.op == `MIPS_OP_BEQ) ? (a == b) : (a != b);
                tgt   = next_pc + simm[29:0];
            end
            `MIPS_OP_J, `MIPS_OP_JAL: begin
                wr    = (w.i.op == `MIPS_OP_JAL);
                dst   = 5'd31;
                res   = {pc + 30'd2, 2'b00};
                taken = 1'b1;
                tgt   = {next_pc[29:26], w.j.target26};
            end
            default: wr = 1'b0;
        endcase
        wv = wr && (dst != 5'd0);
    endtask

    // Sends one instruction and checks its write-back and redirect a cycle later.
    task automatic issue_ins(input mips_pkg::ins_word_t w);
        logic        exp_wv;
        logic [4:0]  exp_reg;
        logic [31:0] exp_data;
        logic        exp_redir;
        logic [29:0] exp_tgt;
        predict(w, cur_pc, exp_wv, exp_reg, exp_data, exp_redir, exp_tgt);
        ins_valid = 1'b1;
        ins_pc    = cur_pc;
        ins_word  = w;
        if (exp_wv) begin
            model_regs[exp_reg] = exp_data;
        end
        cur_pc = cur_pc + 30'd1;
        @(posedge clk);
        #DRIVE_DELAY;
        ins_valid = 1'b0;
        ins_word  = '0;
        check_value("wb_valid", wb_valid, exp_wv);
        check_value("redirect", redirect, exp_redir);
        if (exp_wv) begin
            check_value("wb_reg", wb_reg, exp_reg);
            check_value("wb_data", wb_data, exp_data);
        end
        if (exp_redir) begin
            check_value("redirect_pc", redirect_pc, exp_tgt);
        end
    endtask

    task automatic idle_cycle();
        ins_valid = 1'b0;
        // A jal word without its strobe, which would both write and redirect if it leaked.
        ins_word  = jump_word(`MIPS_OP_JAL, 26'h2ab_cdef);
        @(posedge clk);
        #DRIVE_DELAY;
        check_value("wb_valid on bubble", wb_valid, 1'b0);
        check_value("redirect on bubble", redirect, 1'b0);
    endtask

    task automatic load_const(input logic [4:0] rt, input logic [31:0] value);
        issue_ins(imm_word(`MIPS_OP_LUI, 5'd0, rt, value[31:16]));
        issue_ins(imm_word(`MIPS_OP_ORI, rt, rt, value[15:0]));
    endtask

    task automatic reset_and_bubbles();
        repeat (3) idle_cycle();
        // Writes to r0 are dropped.
        issue_ins(imm_word(`MIPS_OP_ADDIU, 5'd0, 5'd0, 16'h1234));
        issue_ins(rtype_word(`MIPS_FN_ADDU, 5'd0, 5'd0, 5'd0, 5'd0));
        idle_cycle();
    endtask

    task automatic rtype_alu();
        logic [5:0] fn_list [7] = '{`MIPS_FN_ADDU, `MIPS_FN_SUBU, `MIPS_FN_AND,
                                    `MIPS_FN_OR, `MIPS_FN_XOR, `MIPS_FN_SLT, `MIPS_FN_SLL};
        for (int n = 0; n < 4; n++) begin
            load_const(5'd1, $urandom);
            // Equal operands on the last pass.
            load_const(5'd2, (n == 3) ? model_regs[1] : $urandom);
            for (int k = 0; k < 7; k++) begin
                issue_ins(rtype_word(fn_list[k], 5'd1, 5'd2, 5'(3 + k), 5'($urandom)));
            end
        end
    endtask

    task automatic immediate_ops();
        logic [15:0] imm;
        for (int n = 0; n < 4; n++) begin
            imm     = 16'($urandom);
            imm[15] = n[0];
            load_const(5'd9, $urandom);
            issue_ins(imm_word(`MIPS_OP_ADDIU, 5'd9, 5'd10, imm));
            issue_ins(imm_word(`MIPS_OP_ANDI, 5'd9, 5'd11, imm));
            issue_ins(imm_word(`MIPS_OP_ORI, 5'd9, 5'd12, imm));
            issue_ins(imm_word(`MIPS_OP_XORI, 5'd9, 5'd13, imm));
            issue_ins(imm_word(`MIPS_OP_LUI, 5'd0, 5'd14, imm));
        end
    endtask

    task automatic dependent_chain();
        load_const(5'd4, $urandom);
        issue_ins(imm_word(`MIPS_OP_ADDIU, 5'd0, 5'd5, 16'h0003));
        for (int k = 0; k < 8; k++) begin
            case (k % 4)
                0: issue_ins(rtype_word(`MIPS_FN_ADDU, 5'd5, 5'd5, 5'd5, 5'd0));
                1: issue_ins(imm_word(`MIPS_OP_XORI, 5'd5, 5'd5, 16'($urandom)));
                2: issue_ins(rtype_word(`MIPS_FN_SUBU, 5'd5, 5'd4, 5'd5, 5'd0));
                default: issue_ins(rtype_word(`MIPS_FN_SLL, 5'd0, 5'd5, 5'd5, 5'd3));
            endcase
        end
        // Read back from storage, not the bypass.
        idle_cycle();
        issue_ins(rtype_word(`MIPS_FN_OR, 5'd5, 5'd0, 5'd7, 5'd0));
    endtask

    task automatic branches_and_jumps();
        logic [31:0] val;
        val    = $urandom;
        cur_pc = 30'($urandom);
        load_const(5'd6, val);
        load_const(5'd7, val);
        load_const(5'd8, val ^ 32'h0000_0100);
        issue_ins(imm_word(`MIPS_OP_BEQ, 5'd6, 5'd7, 16'($urandom)));
        // Delay slot still retires.
        issue_ins(imm_word(`MIPS_OP_ADDIU, 5'd6, 5'd20, 16'h0001));
        issue_ins(imm_word(`MIPS_OP_BEQ, 5'd6, 5'd8, 16'hfff0));
        issue_ins(imm_word(`MIPS_OP_BNE, 5'd6, 5'd8, 16'($urandom)));
        issue_ins(imm_word(`MIPS_OP_ADDIU, 5'd7, 5'd21, 16'hffff));
        issue_ins(imm_word(`MIPS_OP_BNE, 5'd6, 5'd7, 16'h0004));
        issue_ins(jump_word(`MIPS_OP_J, 26'($urandom)));
        issue_ins(imm_word(`MIPS_OP_ORI, 5'd0, 5'd22, 16'h5a5a));
        issue_ins(jump_word(`MIPS_OP_JAL, 26'($urandom)));
        // Link value seen through the bypass.
        issue_ins(rtype_word(`MIPS_FN_ADDU, 5'd31, 5'd0, 5'd23, 5'd0));
    endtask

    initial begin
        #((TOTAL_CYCLES + 50) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hec4a));
        $timeformat(-9, 0, " ns", 0);
        rst_n     = 1'b0;
        ins_valid = 1'b0;
        ins_pc    = '0;
        ins_word  = '0;
        cur_pc    = '0;
        checks    = 0;
        errors    = 0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        reset_and_bubbles();
        rtype_alu();
        immediate_ops();
        dependent_chain();
        branches_and_jumps();
        prop_errors = mips_id_ex_top_inst.id_ex_inst.id_ex_properties_inst.fail_count;
        $display("Checks: %0d, errors: %0d, property errors: %0d",
                 checks, errors, prop_errors);
        if (errors == 0 && prop_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
